//--- Makefile
# Verilator build and run of the cacheStore testbench.

VERILATOR ?= verilator
TOP       ?= cacheStoreTb
FILELIST  ?= cacheStore.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

# The run passes only when the pass line shows up in the simulator output.
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- cacheStore.f
src/cachePkg.sv
src/dualPortRam.sv
src/cacheDataArray.sv
src/cacheTagArray.sv
src/wayResolver.sv
src/cacheStore.sv
testbench/cacheStoreTb.sv

//--- src/cacheDataArray.sv
// Data array of the cache, muxing the two clients onto one RAM holding all four ways of a set.
`timescale 1ns/100ps

module cacheDataArray (
  input  logic                              clk,
  input  logic                              sel,             // 0 gives rw, 1 gives ri control.
  input  logic [cachePkg::addrWidth-1:0]    rwReadAddress,
  input  logic [cachePkg::addrWidth-1:0]    rwWriteAddress,
  input  logic [cachePkg::wayWidth-1:0]     rwChannel,       // Way written by rw.
  input  logic [cachePkg::bytesPerWord-1:0] rwWriteByteEnable,
  input  logic                              rwWriteEnable,
  input  logic [cachePkg::wordWidth-1:0]    rwWriteData,
  input  logic [cachePkg::addrWidth-1:0]    riReadAddress,
  input  logic [cachePkg::addrWidth-1:0]    riWriteAddress,
  input  logic [cachePkg::wayWidth-1:0]     riChannel,       // Way written by ri.
  input  logic [cachePkg::bytesPerWord-1:0] riWriteByteEnable,
  input  logic                              riWriteEnable,
  input  logic [cachePkg::wordWidth-1:0]    riWriteData,
  output logic [cachePkg::wordWidth-1:0]    wayWord0,        // Word of way 0, one cycle late.
  output logic [cachePkg::wordWidth-1:0]    wayWord1,
  output logic [cachePkg::wordWidth-1:0]    wayWord2,
  output logic [cachePkg::wordWidth-1:0]    wayWord3
);

  logic [cachePkg::addrWidth-1:0]    readAddress;            // Address of the selected client.
  logic [cachePkg::addrWidth-1:0]    writeAddress;
  logic [cachePkg::wayWidth-1:0]     writeChannel;
  logic [cachePkg::bytesPerWord-1:0] writeByteEnable;
  logic                              writeEnable;
  logic [cachePkg::wordWidth-1:0]    writeData;
  logic [cachePkg::numWays-1:0]      wayOneHot;              // Decoded write way.
  logic [cachePkg::numWays*cachePkg::bytesPerWord-1:0] laneEnable;
  cachePkg::byteT [cachePkg::numWays*cachePkg::bytesPerWord-1:0] writeLine;
  cachePkg::byteT [cachePkg::numWays*cachePkg::bytesPerWord-1:0] readLine;

  // The unselected client is ignored completely, strobes included.
  assign readAddress     = sel ? riReadAddress     : rwReadAddress;
  assign writeAddress    = sel ? riWriteAddress    : rwWriteAddress;
  assign writeChannel    = sel ? riChannel         : rwChannel;
  assign writeByteEnable = sel ? riWriteByteEnable : rwWriteByteEnable;
  assign writeEnable     = sel ? riWriteEnable     : rwWriteEnable;
  assign writeData       = sel ? riWriteData       : rwWriteData;

  // Every way sees the same word; the lane enables decide where it lands.
  assign writeLine = {cachePkg::numWays{writeData}};
  assign wayOneHot = {{(cachePkg::numWays-1){1'b0}}, 1'b1} << writeChannel;

  // Byte enables are repeated per way and masked by the one-hot way.
  always_comb begin
    for (int way = 0; way < cachePkg::numWays; way++) begin
      laneEnable[way*cachePkg::bytesPerWord +: cachePkg::bytesPerWord] =
        {cachePkg::bytesPerWord{wayOneHot[way]}} & writeByteEnable;
    end
  end

  dualPortRam #(
    .laneT    (cachePkg::byteT),
    .numLanes (cachePkg::numWays * cachePkg::bytesPerWord),
    .depth    (2 ** cachePkg::addrWidth)
  ) dataRam (
    .clk             (clk),
    .readAddress     (readAddress),
    .writeAddress    (writeAddress),
    .writeEnable     (writeEnable),
    .writeLaneEnable (laneEnable),
    .writeData       (writeLine),
    .readData        (readLine)
  );

  // Way 0 sits in the lowest four lanes.
  assign wayWord0 = readLine[3:0];
  assign wayWord1 = readLine[7:4];
  assign wayWord2 = readLine[11:8];
  assign wayWord3 = readLine[15:12];

endmodule

//--- src/cachePkg.sv
// Cache geometry constants and the shared tag-entry and byte-lane types.
package cachePkg;

  localparam int addrWidth    = 6;                 // Set index width, 64 sets.
  localparam int numWays      = 4;                 // Ways in every set.
  localparam int wayWidth     = 2;                 // Enough bits to name one way.
  localparam int wordWidth    = 32;                // One word per way.
  localparam int bytesPerWord = wordWidth / 8;     // Byte enables per word.
  localparam int tagWidth     = 20;                // Stored tag bits.

  // One tag RAM lane per way.
  typedef struct packed {
    logic                valid;                    // Entry holds a live line.
    logic [tagWidth-1:0] tag;                      // Upper address bits of the line.
  } tagEntryT;

  // Data RAM lane, one byte so byte enables map to lanes directly.
  typedef logic [7:0] byteT;

endpackage

//--- src/cacheStore.sv
// Storage half of a four-way set-associative cache shared by the processor and refill clients.
`timescale 1ns/100ps

module cacheStore (
  input  logic                              clk,
  input  logic                              arstN,
  input  logic                              sel,              // 0 gives rw, 1 gives ri control.
  // Processor read/write client.
  input  logic [cachePkg::addrWidth-1:0]    rwReadAddress,
  input  logic [cachePkg::tagWidth-1:0]     rwTag,
  input  logic [cachePkg::wayWidth-1:0]     rwChannel,
  input  logic [cachePkg::addrWidth-1:0]    rwWriteAddress,
  input  logic [cachePkg::bytesPerWord-1:0] rwWriteByteEnable,
  input  logic                              rwWriteEnable,
  input  logic [cachePkg::wordWidth-1:0]    rwWriteData,
  output logic [cachePkg::wordWidth-1:0]    rwReadData,
  output logic                              hit,
  output logic [cachePkg::wayWidth-1:0]     hitWay,
  // Refill and inspection client.
  input  logic [cachePkg::addrWidth-1:0]    riReadAddress,
  input  logic [cachePkg::wayWidth-1:0]     riChannel,
  input  logic [cachePkg::addrWidth-1:0]    riWriteAddress,
  input  logic [cachePkg::bytesPerWord-1:0] riWriteByteEnable,
  input  logic                              riWriteEnable,
  input  logic [cachePkg::wordWidth-1:0]    riWriteData,
  input  logic                              riTagWrite,
  input  cachePkg::tagEntryT                riTagEntry,
  output logic [cachePkg::wordWidth-1:0]    riReadData
);

  logic [cachePkg::wordWidth-1:0] wayWord0;               // Data array outputs, one per way.
  logic [cachePkg::wordWidth-1:0] wayWord1;
  logic [cachePkg::wordWidth-1:0] wayWord2;
  logic [cachePkg::wordWidth-1:0] wayWord3;
  cachePkg::tagEntryT             tagEntry0;              // Tag array outputs, one per way.
  cachePkg::tagEntryT             tagEntry1;
  cachePkg::tagEntryT             tagEntry2;
  cachePkg::tagEntryT             tagEntry3;

  // Both arrays take sel in the same cycle, so their reads stay aligned.
  cacheDataArray dataArray (
    .clk               (clk),
    .sel               (sel),
    .rwReadAddress     (rwReadAddress),
    .rwWriteAddress    (rwWriteAddress),
    .rwChannel         (rwChannel),
    .rwWriteByteEnable (rwWriteByteEnable),
    .rwWriteEnable     (rwWriteEnable),
    .rwWriteData       (rwWriteData),
    .riReadAddress     (riReadAddress),
    .riWriteAddress    (riWriteAddress),
    .riChannel         (riChannel),
    .riWriteByteEnable (riWriteByteEnable),
    .riWriteEnable     (riWriteEnable),
    .riWriteData       (riWriteData),
    .wayWord0          (wayWord0),
    .wayWord1          (wayWord1),
    .wayWord2          (wayWord2),
    .wayWord3          (wayWord3)
  );

  cacheTagArray tagArray (
    .clk            (clk),
    .sel            (sel),
    .rwReadAddress  (rwReadAddress),
    .riReadAddress  (riReadAddress),
    .riWriteAddress (riWriteAddress),
    .riChannel      (riChannel),
    .riTagWrite     (riTagWrite),
    .riTagEntry     (riTagEntry),
    .tagEntry0      (tagEntry0),
    .tagEntry1      (tagEntry1),
    .tagEntry2      (tagEntry2),
    .tagEntry3      (tagEntry3)
  );

  // The resolver delays rwTag, riChannel and sel by the RAM latency.
  wayResolver resolver (
    .clk        (clk),
    .arstN      (arstN),
    .sel        (sel),
    .rwTag      (rwTag),
    .riChannel  (riChannel),
    .wayWord0   (wayWord0),
    .wayWord1   (wayWord1),
    .wayWord2   (wayWord2),
    .wayWord3   (wayWord3),
    .tagEntry0  (tagEntry0),
    .tagEntry1  (tagEntry1),
    .tagEntry2  (tagEntry2),
    .tagEntry3  (tagEntry3),
    .hit        (hit),
    .hitWay     (hitWay),
    .rwReadData (rwReadData),
    .riReadData (riReadData)
  );

endmodule

//--- src/cacheTagArray.sv
// Tag array of the cache, read by either client and written only through the refill path.
`timescale 1ns/100ps

module cacheTagArray (
  input  logic                           clk,
  input  logic                           sel,            // Chooses the read address source.
  input  logic [cachePkg::addrWidth-1:0] rwReadAddress,
  input  logic [cachePkg::addrWidth-1:0] riReadAddress,
  input  logic [cachePkg::addrWidth-1:0] riWriteAddress,
  input  logic [cachePkg::wayWidth-1:0]  riChannel,      // Way whose tag is replaced.
  input  logic                           riTagWrite,     // Tag write strobe from ri.
  input  cachePkg::tagEntryT             riTagEntry,
  output cachePkg::tagEntryT             tagEntry0,      // Entry of way 0, one cycle late.
  output cachePkg::tagEntryT             tagEntry1,
  output cachePkg::tagEntryT             tagEntry2,
  output cachePkg::tagEntryT             tagEntry3
);

  logic [cachePkg::addrWidth-1:0]               readAddress;
  logic                                         writeEnable;    // Only ri may touch tags.
  logic [cachePkg::numWays-1:0]                 wayOneHot;
  cachePkg::tagEntryT [cachePkg::numWays-1:0]   writeLine;
  cachePkg::tagEntryT [cachePkg::numWays-1:0]   readLine;

  assign readAddress = sel ? riReadAddress : rwReadAddress;

  // A tag strobe while rw owns the arrays is dropped.
  assign writeEnable = sel & riTagWrite;
  assign wayOneHot   = {{(cachePkg::numWays-1){1'b0}}, 1'b1} << riChannel;
  assign writeLine   = {cachePkg::numWays{riTagEntry}};    // Same entry offered to every way.

  dualPortRam #(
    .laneT    (cachePkg::tagEntryT),
    .numLanes (cachePkg::numWays),
    .depth    (2 ** cachePkg::addrWidth)
  ) tagRam (
    .clk             (clk),
    .readAddress     (readAddress),
    .writeAddress    (riWriteAddress),
    .writeEnable     (writeEnable),
    .writeLaneEnable (wayOneHot),
    .writeData       (writeLine),
    .readData        (readLine)
  );

  // One lane per way, way 0 in lane 0.
  assign tagEntry0 = readLine[0];
  assign tagEntry1 = readLine[1];
  assign tagEntry2 = readLine[2];
  assign tagEntry3 = readLine[3];

endmodule

//--- src/dualPortRam.sv
// Lane-addressed RAM with one registered read port and one byte/lane-masked write port.
`timescale 1ns/100ps

module dualPortRam #(
  parameter type laneT = logic [7:0],              // Payload stored in each lane.
  parameter int numLanes = 4,                      // Lanes per RAM word.
  parameter int depth = 64                         // Number of RAM words.
) (
  input  logic                       clk,
  input  logic [$clog2(depth)-1:0]   readAddress,  // Sampled at the rising edge.
  input  logic [$clog2(depth)-1:0]   writeAddress,
  input  logic                       writeEnable,  // Global write strobe.
  input  logic [numLanes-1:0]        writeLaneEnable, // One bit per lane.
  input  laneT [numLanes-1:0]        writeData,
  output laneT [numLanes-1:0]        readData      // Valid one cycle after the address.
);

  laneT [numLanes-1:0] mem [depth];                // Contents are undefined until written.

  // Each lane is written on its own, so a partial write keeps the other lanes.
  always_ff @(posedge clk) begin
    if (writeEnable) begin
      for (int lane = 0; lane < numLanes; lane++) begin
        if (writeLaneEnable[lane]) begin
          mem[writeAddress][lane] <= writeData[lane]; // Only enabled lanes change.
        end
      end
    end
  end

  // Nonblocking read gives read-first behaviour on a same-address collision.
  always_ff @(posedge clk) begin
    readData <= mem[readAddress];                  // Old word returned during a write.
  end

endmodule

//--- src/wayResolver.sv
// Way resolver, comparing the set's tags with the lookup tag and picking words for both clients.
`timescale 1ns/100ps

module wayResolver (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           sel,
  input  logic [cachePkg::tagWidth-1:0]  rwTag,         // Lookup tag, aligned with rwReadAddress.
  input  logic [cachePkg::wayWidth-1:0]  riChannel,     // Way that ri reads back.
  input  logic [cachePkg::wordWidth-1:0] wayWord0,
  input  logic [cachePkg::wordWidth-1:0] wayWord1,
  input  logic [cachePkg::wordWidth-1:0] wayWord2,
  input  logic [cachePkg::wordWidth-1:0] wayWord3,
  input  cachePkg::tagEntryT             tagEntry0,
  input  cachePkg::tagEntryT             tagEntry1,
  input  cachePkg::tagEntryT             tagEntry2,
  input  cachePkg::tagEntryT             tagEntry3,
  output logic                           hit,
  output logic [cachePkg::wayWidth-1:0]  hitWay,        // Lowest matching way, 0 on a miss.
  output logic [cachePkg::wordWidth-1:0] rwReadData,    // Hit word, 0 on a miss.
  output logic [cachePkg::wordWidth-1:0] riReadData
);

  logic [cachePkg::tagWidth-1:0]  tagQ;                 // Lookup tag delayed to match the RAM.
  logic [cachePkg::wayWidth-1:0]  channelQ;
  logic                           selQ;                 // Owner of the data now on the RAM outputs.
  logic [cachePkg::wordWidth-1:0] words [cachePkg::numWays];
  cachePkg::tagEntryT             entries [cachePkg::numWays];
  logic [cachePkg::numWays-1:0]   matchVec;             // One bit per valid, equal tag.
  logic [cachePkg::wayWidth-1:0]  matchWay;

  // Lines the side information up with the synchronous RAM read.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      tagQ     <= '0;
      channelQ <= '0;
      selQ     <= 1'b0;
    end else begin
      tagQ     <= rwTag;
      channelQ <= riChannel;
      selQ     <= sel;
    end
  end

  assign words   = '{wayWord0, wayWord1, wayWord2, wayWord3};
  assign entries = '{tagEntry0, tagEntry1, tagEntry2, tagEntry3};

  // Walking down from the top leaves the lowest match in matchWay.
  always_comb begin
    matchWay = '0;
    for (int way = cachePkg::numWays - 1; way >= 0; way--) begin
      matchVec[way] = entries[way].valid && (entries[way].tag == tagQ);
      if (matchVec[way]) begin
        matchWay = way[cachePkg::wayWidth-1:0];
      end
    end
  end

  assign hit        = (|matchVec) & ~selQ;              // No hits reported while ri owned the read.
  assign hitWay     = hit ? matchWay : '0;
  assign rwReadData = hit ? words[matchWay] : '0;
  assign riReadData = words[channelQ];                  // Named way, regardless of tags.

endmodule

//--- testbench/cacheStoreTb.sv
// Table-driven testbench for the cache storage block, checked against a model of data and tags.
`timescale 1ns/100ps

module cacheStoreTb;

  localparam int numSets     = 2 ** cachePkg::addrWidth;  // Sets in both arrays.
  localparam int resetCycles = 10;                        // Cycles with arstN held low.

  typedef enum logic [2:0] {
    opLookup,                                             // Read only, rw view.
    opInspect,                                            // Read only, ri view.
    opRwWrite,                                            // Data write strobe on rw.
    opRiWrite,                                            // Data write strobe on ri.
    opTagWrite                                            // Tag write strobe on ri.
  } opKindT;

  typedef struct packed {
    logic                              sel;               // Client in control this cycle.
    opKindT                            kind;
    logic [cachePkg::addrWidth-1:0]    addr;              // Read and write set index.
    logic [cachePkg::wayWidth-1:0]     way;               // Channel for both clients.
    logic [cachePkg::bytesPerWord-1:0] byteEnable;
    logic [cachePkg::wordWidth-1:0]    data;
    logic [cachePkg::tagWidth-1:0]     tag;               // Lookup tag and tag-write payload.
    logic                              tagValid;          // Valid bit for a tag write.
  } opT;

  logic                              clk;
  logic                              arstN;
  logic                              sel;
  logic [cachePkg::addrWidth-1:0]    rwReadAddress;
  logic [cachePkg::tagWidth-1:0]     rwTag;
  logic [cachePkg::wayWidth-1:0]     rwChannel;
  logic [cachePkg::addrWidth-1:0]    rwWriteAddress;
  logic [cachePkg::bytesPerWord-1:0] rwWriteByteEnable;
  logic                              rwWriteEnable;
  logic [cachePkg::wordWidth-1:0]    rwWriteData;
  logic [cachePkg::wordWidth-1:0]    rwReadData;
  logic                              hit;
  logic [cachePkg::wayWidth-1:0]     hitWay;
  logic [cachePkg::addrWidth-1:0]    riReadAddress;
  logic [cachePkg::wayWidth-1:0]     riChannel;
  logic [cachePkg::addrWidth-1:0]    riWriteAddress;
  logic [cachePkg::bytesPerWord-1:0] riWriteByteEnable;
  logic                              riWriteEnable;
  logic [cachePkg::wordWidth-1:0]    riWriteData;
  logic                              riTagWrite;
  cachePkg::tagEntryT                riTagEntry;
  logic [cachePkg::wordWidth-1:0]    riReadData;

  opT                             opTable [$];            // Stimulus in the order it is applied.
  logic [cachePkg::wordWidth-1:0] modelData [numSets][cachePkg::numWays];
  cachePkg::tagEntryT             modelTag [numSets][cachePkg::numWays];
  int                             cycleCount = 0;
  int                             cycleLimit = 0;         // Set once the table is built.
  int unsigned                    seedValue;

  cacheStore uut (
    .clk               (clk),
    .arstN             (arstN),
    .sel               (sel),
    .rwReadAddress     (rwReadAddress),
    .rwTag             (rwTag),
    .rwChannel         (rwChannel),
    .rwWriteAddress    (rwWriteAddress),
    .rwWriteByteEnable (rwWriteByteEnable),
    .rwWriteEnable     (rwWriteEnable),
    .rwWriteData       (rwWriteData),
    .rwReadData        (rwReadData),
    .hit               (hit),
    .hitWay            (hitWay),
    .riReadAddress     (riReadAddress),
    .riChannel         (riChannel),
    .riWriteAddress    (riWriteAddress),
    .riWriteByteEnable (riWriteByteEnable),
    .riWriteEnable     (riWriteEnable),
    .riWriteData       (riWriteData),
    .riTagWrite        (riTagWrite),
    .riTagEntry        (riTagEntry),
    .riReadData        (riReadData)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                                // 10 ns period.
  end

  // Watchdog on rising edges.
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles.", cycleLimit);
      $display("Some tests failed");
      $fatal(1, "Simulation stopped by the watchdog.");
    end
  end

  function automatic logic [cachePkg::wordWidth-1:0] randomWord();
    return $urandom;
  endfunction

  function automatic logic [cachePkg::tagWidth-1:0] randomTag();
    logic [31:0] raw;
    raw = $urandom;
    return raw[cachePkg::tagWidth-1:0];                   // Upper bits dropped.
  endfunction

  // Fill word carries the full set and way, so any misrouted read shows up.
  function automatic logic [cachePkg::wordWidth-1:0] fillWord(input int s, input int w);
    return {16'hC0DE, 8'h5A, s[cachePkg::addrWidth-1:0], w[cachePkg::wayWidth-1:0]};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s: actual %h, expected %h", $time, name, actual, expected);
      $display("Some tests failed");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic addOp(input logic selIn, input opKindT kind, input int addr, input int way,
                       input logic [cachePkg::bytesPerWord-1:0] byteEnable,
                       input logic [cachePkg::wordWidth-1:0] data,
                       input logic [cachePkg::tagWidth-1:0] tag, input logic tagValid);
    opT op;
    op.sel        = selIn;
    op.kind       = kind;
    op.addr       = addr[cachePkg::addrWidth-1:0];
    op.way        = way[cachePkg::wayWidth-1:0];
    op.byteEnable = byteEnable;
    op.data       = data;
    op.tag        = tag;
    op.tagValid   = tagValid;
    opTable.push_back(op);
  endtask

  task automatic buildTable();
    logic [cachePkg::tagWidth-1:0] tagA;
    logic [cachePkg::tagWidth-1:0] tagB;
    logic [cachePkg::tagWidth-1:0] tagC;
    tagA = randomTag();
    tagB = randomTag();
    tagC = randomTag();
    for (int s = 0; s < numSets; s++) begin               // The cleared tags match but are not valid.
      addOp(1'b0, opLookup, s, s % cachePkg::numWays, '0, '0, '0, 1'b0);
    end
    addOp(1'b1, opTagWrite, 5, 2, '0, '0, tagA, 1'b1);    // Install tagA in way 2 of set 5.
    addOp(1'b0, opLookup, 5, 2, '0, '0, tagA, 1'b0);
    addOp(1'b0, opLookup, 5, 0, '0, '0, tagA ^ 20'h00001, 1'b0);
    addOp(1'b0, opRwWrite, 5, 2, 4'hF, randomWord(), tagA, 1'b0); // Lookup sees the old word.
    addOp(1'b0, opLookup, 5, 2, '0, '0, tagA, 1'b0);
    for (int w = 0; w < cachePkg::numWays; w++) begin     // Known words in all ways of set 9.
      addOp(1'b1, opRiWrite, 9, w, 4'hF, randomWord(), '0, 1'b0);
    end
    addOp(1'b0, opRwWrite, 9, 1, 4'b0101, randomWord(), '0, 1'b0);
    for (int w = 0; w < cachePkg::numWays; w++) begin
      addOp(1'b1, opInspect, 9, w, '0, '0, '0, 1'b0);
    end
    addOp(1'b0, opRwWrite, 9, 3, 4'b1000, randomWord(), '0, 1'b0);
    addOp(1'b0, opRwWrite, 9, 0, 4'b0010, randomWord(), '0, 1'b0);
    for (int w = 0; w < cachePkg::numWays; w++) begin
      addOp(1'b1, opInspect, 9, w, '0, '0, '0, 1'b0);
    end
    addOp(1'b1, opTagWrite, 12, 3, '0, '0, tagB, 1'b1);   // Same tag in several ways.
    addOp(1'b1, opTagWrite, 12, 1, '0, '0, tagB, 1'b1);
    addOp(1'b1, opTagWrite, 12, 2, '0, '0, tagB, 1'b1);
    addOp(1'b0, opLookup, 12, 0, '0, '0, tagB, 1'b0);
    addOp(1'b1, opTagWrite, 12, 1, '0, '0, tagB, 1'b0);   // Drop way 1 from the match.
    addOp(1'b0, opLookup, 12, 0, '0, '0, tagB, 1'b0);
    addOp(1'b1, opTagWrite, 12, 0, '0, '0, tagB, 1'b1);
    addOp(1'b0, opLookup, 12, 0, '0, '0, tagB, 1'b0);
    addOp(1'b1, opRwWrite, 9, 0, 4'hF, randomWord(), '0, 1'b0); // rw is not in control here.
    addOp(1'b1, opInspect, 9, 0, '0, '0, '0, 1'b0);
    addOp(1'b0, opRiWrite, 9, 2, 4'hF, randomWord(), '0, 1'b0); // Nor is ri here.
    addOp(1'b1, opInspect, 9, 2, '0, '0, '0, 1'b0);
    addOp(1'b0, opTagWrite, 20, 0, '0, '0, tagC, 1'b1);   // Tag strobe while rw owns the arrays.
    addOp(1'b0, opLookup, 20, 0, '0, '0, tagC, 1'b0);
    addOp(1'b1, opLookup, 5, 2, '0, '0, tagA, 1'b0);      // Matching tag, but ri owns the read.
    addOp(1'b0, opLookup, 5, 2, '0, '0, tagA, 1'b0);
    addOp(1'b1, opRiWrite, 30, 0, 4'hF, randomWord(), '0, 1'b0);
    addOp(1'b1, opRiWrite, 30, 0, 4'hF, randomWord(), '0, 1'b0); // Read returns the first word.
    addOp(1'b1, opInspect, 30, 0, '0, '0, '0, 1'b0);
  endtask

  task automatic driveOp(input opT op);
    sel               = op.sel;
    rwReadAddress     = op.addr;
    riReadAddress     = op.addr;
    rwWriteAddress    = op.addr;
    riWriteAddress    = op.addr;
    rwTag             = op.tag;
    rwChannel         = op.way;
    riChannel         = op.way;
    rwWriteByteEnable = op.byteEnable;
    riWriteByteEnable = op.byteEnable;
    rwWriteData       = op.data;
    riWriteData       = op.data;
    rwWriteEnable     = (op.kind == opRwWrite);
    riWriteEnable     = (op.kind == opRiWrite);
    riTagWrite        = (op.kind == opTagWrite);
    riTagEntry.valid  = op.tagValid;
    riTagEntry.tag    = op.tag;
  endtask

  // Expected outputs come from the model before this cycle's write (read-first).
  task automatic expectOp(input opT op, output logic [31:0] expHit, output logic [31:0] expWay,
                          output logic [31:0] expRw, output logic [31:0] expRi);
    expHit = '0;
    expWay = '0;
    expRw  = '0;
    expRi  = modelData[op.addr][op.way];                  // Named way, tags ignored.
    if (!op.sel) begin
      for (int w = 0; w < cachePkg::numWays; w++) begin   // First match from way 0 wins.
        if (expHit == 0 && modelTag[op.addr][w].valid && modelTag[op.addr][w].tag == op.tag) begin
          expHit = 32'd1;
          expWay = w;
          expRw  = modelData[op.addr][w];
        end
      end
    end
  endtask

  task automatic updateModel(input opT op);
    if (op.kind == opTagWrite && op.sel) begin            // Tags change only under ri control.
      modelTag[op.addr][op.way].valid = op.tagValid;
      modelTag[op.addr][op.way].tag   = op.tag;
    end
    if ((op.kind == opRwWrite && !op.sel) || (op.kind == opRiWrite && op.sel)) begin
      for (int b = 0; b < cachePkg::bytesPerWord; b++) begin
        if (op.byteEnable[b]) begin
          modelData[op.addr][op.way][b*8 +: 8] = op.data[b*8 +: 8];
        end
      end
    end
  endtask

  // One way per cycle: clear the tag and load the fill word.
  task automatic invalidateAll();
    for (int s = 0; s < numSets; s++) begin
      for (int w = 0; w < cachePkg::numWays; w++) begin
        sel               = 1'b1;
        rwReadAddress     = s[cachePkg::addrWidth-1:0];
        riReadAddress     = s[cachePkg::addrWidth-1:0];
        riWriteAddress    = s[cachePkg::addrWidth-1:0];
        riChannel         = w[cachePkg::wayWidth-1:0];
        riWriteByteEnable = '1;
        riWriteEnable     = 1'b1;
        riWriteData       = fillWord(s, w);
        riTagWrite        = 1'b1;
        riTagEntry        = '0;
        modelData[s][w]   = fillWord(s, w);
        modelTag[s][w]    = '0;
        @(negedge clk);
        checkValue("hit", 32'(hit), 32'd0);               // sel was 1 for this read.
      end
    end
    riWriteEnable = 1'b0;
    riTagWrite    = 1'b0;
  endtask

  initial begin
    logic [31:0] expHit;
    logic [31:0] expWay;
    logic [31:0] expRw;
    logic [31:0] expRi;
    arstN             = 1'b0;
    sel               = 1'b1;                             // Keeps hit defined right after reset.
    rwReadAddress     = '0;
    rwTag             = '0;
    rwChannel         = '0;
    rwWriteAddress    = '0;
    rwWriteByteEnable = '0;
    rwWriteEnable     = 1'b0;
    rwWriteData       = '0;
    riReadAddress     = '0;
    riChannel         = '0;
    riWriteAddress    = '0;
    riWriteByteEnable = '0;
    riWriteEnable     = 1'b0;
    riWriteData       = '0;
    riTagWrite        = 1'b0;
    riTagEntry        = '0;
    seedValue         = $urandom(32'h2f48);
    buildTable();
    cycleLimit = resetCycles + numSets * cachePkg::numWays + 2 * opTable.size() + 20;
    repeat (resetCycles) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);
    checkValue("hit", 32'(hit), 32'd0);
    checkValue("hitWay", 32'(hitWay), 32'd0);
    invalidateAll();
    foreach (opTable[i]) begin
      driveOp(opTable[i]);
      expectOp(opTable[i], expHit, expWay, expRw, expRi);
      updateModel(opTable[i]);
      @(negedge clk);                                     // Outputs settled after one edge.
      checkValue("hit", 32'(hit), expHit);
      checkValue("hitWay", 32'(hitWay), expWay);
      checkValue("rwReadData", rwReadData, expRw);
      checkValue("riReadData", riReadData, expRi);
    end
    rwWriteEnable = 1'b0;
    riWriteEnable = 1'b0;
    riTagWrite    = 1'b0;
    $display("All tests passed");
    $finish;
  end

endmodule
